// ==== Bender.yml ====
package:
  name: stream_mux

sources:
  - hdl/stream_mux_pkg.sv
  - hdl/stream_mux_ingress.sv
  - hdl/stream_mux_node.sv
  - hdl/stream_mux_egress.sv
  - hdl/stream_mux_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_stream_mux.sv

// ==== hdl/stream_mux_egress.sv ====
module stream_mux_egress
    import stream_mux_pkg::*;
(
    input  logic   aclk,
    input  logic   arst_n,

    // from the tree root.
    input  logic   s_tvalid,
    output logic   s_tready,
    input  tdata_t s_tdata,
    input  tkeep_t s_tkeep,
    input  logic   s_tlast,
    input  tid_t   s_tid,

    // tx port.
    output logic   tx_tvalid,
    input  logic   tx_tready,
    output tdata_t tx_tdata,
    output tkeep_t tx_tkeep,
    output logic   tx_tlast,
    output tid_t   tx_tid
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // skid entry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic   skid_valid;     // overflow beat held.
    tdata_t skid_tdata;
    tkeep_t skid_tkeep;
    logic   skid_tlast;
    tid_t   skid_tid;

    logic   main_load;      // main register may take a beat.
    logic   s_take;         // upstream transfer.

    // ready from a flop only, tx_tready never reaches the root.
    assign s_tready  = !skid_valid;
    assign s_take    = s_tvalid && s_tready;
    assign main_load = !tx_tvalid || tx_tready;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            tx_tvalid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (main_load) begin
            // skid drains first.
            tx_tvalid  <= skid_valid || s_take;
            skid_valid <= 1'b0;
        end else if (s_take) begin
            skid_valid <= 1'b1;             // tx stalled, park it.
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // payload
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge aclk) begin
        if (main_load && skid_valid) begin
            tx_tdata <= skid_tdata;         // older beat.
            tx_tkeep <= skid_tkeep;
            tx_tlast <= skid_tlast;
            tx_tid   <= skid_tid;
        end else if (main_load && s_take) begin
            tx_tdata <= s_tdata;
            tx_tkeep <= s_tkeep;
            tx_tlast <= s_tlast;
            tx_tid   <= s_tid;
        end

        if (!main_load && s_take) begin
            skid_tdata <= s_tdata;
            skid_tkeep <= s_tkeep;
            skid_tlast <= s_tlast;
            skid_tid   <= s_tid;
        end
    end

endmodule

// ==== hdl/stream_mux_ingress.sv ====
module stream_mux_ingress
    import stream_mux_pkg::*;
(
    // rx side, one entry per stream.
    input  logic   rx_tvalid   [stream_inputs],
    output logic   rx_tready   [stream_inputs],
    input  tdata_t rx_tdata    [stream_inputs],
    input  tkeep_t rx_tkeep    [stream_inputs],
    input  logic   rx_tlast    [stream_inputs],

    // leaf side, padded to tree_slots.
    output logic   leaf_tvalid [tree_slots],
    input  logic   leaf_tready [tree_slots],
    output tdata_t leaf_tdata  [tree_slots],
    output tkeep_t leaf_tkeep  [tree_slots],
    output logic   leaf_tlast  [tree_slots],
    output tid_t   leaf_tid    [tree_slots]
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // slot mapping
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // rx k lands on leaf k.
    // no registers here, the leaf sees rx directly.

    for (genvar k = 0; k < tree_slots; k++) begin : g_slot
        if (k < stream_inputs) begin : g_used
            assign leaf_tvalid[k] = rx_tvalid[k];
            assign leaf_tdata[k]  = rx_tdata[k];
            assign leaf_tkeep[k]  = rx_tkeep[k];
            assign leaf_tlast[k]  = rx_tlast[k];
            assign leaf_tid[k]    = tid_t'(k);        // stamp source.

            // backpressure straight from the leaf node.
            assign rx_tready[k] = leaf_tready[k];
        end else begin : g_pad
            // padding slot, never requests.
            assign leaf_tvalid[k] = 1'b0;
            assign leaf_tdata[k]  = '0;               // don't care.
            assign leaf_tkeep[k]  = '0;               // don't care.
            assign leaf_tlast[k]  = 1'b0;
            assign leaf_tid[k]    = tid_t'(k);

            // tready of this slot goes nowhere.
        end
    end

    // the node above a pad slot only ever grants its
    // other child, so the pad's tready is never seen
    // high together with a valid beat.

endmodule

// ==== hdl/stream_mux_node.sv ====
module stream_mux_node
    import stream_mux_pkg::*;
(
    input  logic   aclk,
    input  logic   arst_n,

    // child a.
    input  logic   a_tvalid,
    output logic   a_tready,
    input  tdata_t a_tdata,
    input  tkeep_t a_tkeep,
    input  logic   a_tlast,
    input  tid_t   a_tid,

    // child b.
    input  logic   b_tvalid,
    output logic   b_tready,
    input  tdata_t b_tdata,
    input  tkeep_t b_tkeep,
    input  logic   b_tlast,
    input  tid_t   b_tid,

    // parent.
    output logic   m_tvalid,
    input  logic   m_tready,
    output tdata_t m_tdata,
    output tkeep_t m_tkeep,
    output logic   m_tlast,
    output tid_t   m_tid
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // arbiter state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic locked;       // packet in progress.
    logic lock_sel;     // child that owns the packet.
    logic rr_ptr;       // favored child on a tie.

    logic grant;        // 0 picks a, 1 picks b.
    logic grant_valid;  // granted child has a beat.
    logic grant_last;   // that beat closes the packet.
    logic out_free;     // output register empty or draining.
    logic take;         // beat accepted this cycle.

    // pick a child.
    always_comb begin
        if (locked) begin
            grant = lock_sel;               // stay on the open packet.
        end else if (a_tvalid && b_tvalid) begin
            grant = rr_ptr;                 // both wait, take turns.
        end else begin
            // lone requester wins.
            // idle parks on a.
            grant = b_tvalid;
        end
    end

    assign grant_valid = grant ? b_tvalid : a_tvalid;
    assign grant_last  = grant ? b_tlast  : a_tlast;

    // room when empty or the parent pulls this cycle.
    assign out_free = !m_tvalid || m_tready;
    assign take     = grant_valid && out_free;

    // only the granted side sees ready.
    assign a_tready = out_free && !grant;
    assign b_tready = out_free && grant;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lock and pointer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            locked   <= 1'b0;
            lock_sel <= 1'b0;
            rr_ptr   <= 1'b0;               // child a first.
        end else if (take) begin
            if (grant_last) begin
                // packet done.
                locked <= 1'b0;
                rr_ptr <= !grant;           // other child next.
            end else begin
                locked   <= 1'b1;
                lock_sel <= grant;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // valid bit.
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            m_tvalid <= 1'b0;
        end else if (out_free) begin
            m_tvalid <= grant_valid;        // refill or go empty.
        end
    end

    // payload, loads only on accept.
    always_ff @(posedge aclk) begin
        if (take) begin
            if (grant) begin
                m_tdata <= b_tdata;
                m_tkeep <= b_tkeep;
                m_tlast <= b_tlast;
                m_tid   <= b_tid;
            end else begin
                m_tdata <= a_tdata;
                m_tkeep <= a_tkeep;
                m_tlast <= a_tlast;
                m_tid   <= a_tid;
            end
        end
    end

    // one beat of latency per node.
    // a full register that stalls holds its beat
    // and drops ready on both children.

endmodule

// ==== hdl/stream_mux_pkg.sv ====
package stream_mux_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // tree shape
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // number of rx streams.
    localparam int stream_inputs = 4;

    // node levels with the root at level 0.
    localparam int tree_depth = (stream_inputs > 1) ? $clog2(stream_inputs) : 1;

    // leaf count after padding to a power of two.
    localparam int tree_slots = 2 ** tree_depth;

    // heap entries for nodes plus leaves.
    localparam int tree_links = (2 * tree_slots) - 1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // beat fields
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int tdata_bytes = 4;                 // bytes per beat.
    localparam int tdata_width = 8 * tdata_bytes;   // bits per beat.

    // source id with one bit per tree level.
    localparam int tid_width = tree_depth;

    typedef logic [tdata_width-1:0] tdata_t;        // data word.
    typedef logic [tdata_bytes-1:0] tkeep_t;        // byte enables.
    typedef logic [tid_width-1:0]   tid_t;          // source number.

    // a beat with tid k came in on rx k.
    // the ingress stamps the whole tid,
    // the nodes only carry it up.

endpackage

// ==== hdl/stream_mux_top.sv ====
module stream_mux_top
    import stream_mux_pkg::*;
(
    input  logic   aclk,
    input  logic   arst_n,

    // rx streams.
    input  logic   rx_tvalid [stream_inputs],
    output logic   rx_tready [stream_inputs],
    input  tdata_t rx_tdata  [stream_inputs],
    input  tkeep_t rx_tkeep  [stream_inputs],
    input  logic   rx_tlast  [stream_inputs],

    // merged stream.
    output logic   tx_tvalid,
    input  logic   tx_tready,
    output tdata_t tx_tdata,
    output tkeep_t tx_tkeep,
    output logic   tx_tlast,
    output tid_t   tx_tid
);

    // heap order, 0 is the root.
    // children of i sit at 2i+1 and 2i+2.
    logic   lvl_tvalid [tree_links];
    logic   lvl_tready [tree_links];
    tdata_t lvl_tdata  [tree_links];
    tkeep_t lvl_tkeep  [tree_links];
    logic   lvl_tlast  [tree_links];
    tid_t   lvl_tid    [tree_links];

    // leaves fill the upper half of the heap.
    stream_mux_ingress i_ingress (
        .rx_tvalid   (rx_tvalid),
        .rx_tready   (rx_tready),
        .rx_tdata    (rx_tdata),
        .rx_tkeep    (rx_tkeep),
        .rx_tlast    (rx_tlast),
        .leaf_tvalid (lvl_tvalid[tree_slots-1:tree_links-1]),
        .leaf_tready (lvl_tready[tree_slots-1:tree_links-1]),
        .leaf_tdata  (lvl_tdata[tree_slots-1:tree_links-1]),
        .leaf_tkeep  (lvl_tkeep[tree_slots-1:tree_links-1]),
        .leaf_tlast  (lvl_tlast[tree_slots-1:tree_links-1]),
        .leaf_tid    (lvl_tid[tree_slots-1:tree_links-1])
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // arbitration tree
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar lvl = 0; lvl < tree_depth; lvl++) begin : g_level
        for (genvar pos = 0; pos < 2 ** lvl; pos++) begin : g_pos
            localparam int n = (2 ** lvl) - 1 + pos;     // own heap entry.

            stream_mux_node i_node (
                .aclk     (aclk),
                .arst_n   (arst_n),
                .a_tvalid (lvl_tvalid[2*n+1]),
                .a_tready (lvl_tready[2*n+1]),
                .a_tdata  (lvl_tdata[2*n+1]),
                .a_tkeep  (lvl_tkeep[2*n+1]),
                .a_tlast  (lvl_tlast[2*n+1]),
                .a_tid    (lvl_tid[2*n+1]),
                .b_tvalid (lvl_tvalid[2*n+2]),
                .b_tready (lvl_tready[2*n+2]),
                .b_tdata  (lvl_tdata[2*n+2]),
                .b_tkeep  (lvl_tkeep[2*n+2]),
                .b_tlast  (lvl_tlast[2*n+2]),
                .b_tid    (lvl_tid[2*n+2]),
                .m_tvalid (lvl_tvalid[n]),
                .m_tready (lvl_tready[n]),
                .m_tdata  (lvl_tdata[n]),
                .m_tkeep  (lvl_tkeep[n]),
                .m_tlast  (lvl_tlast[n]),
                .m_tid    (lvl_tid[n])
            );
        end
    end

    // root drains into the skid buffer.
    stream_mux_egress i_egress (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .s_tvalid  (lvl_tvalid[0]),
        .s_tready  (lvl_tready[0]),
        .s_tdata   (lvl_tdata[0]),
        .s_tkeep   (lvl_tkeep[0]),
        .s_tlast   (lvl_tlast[0]),
        .s_tid     (lvl_tid[0]),
        .tx_tvalid (tx_tvalid),
        .tx_tready (tx_tready),
        .tx_tdata  (tx_tdata),
        .tx_tkeep  (tx_tkeep),
        .tx_tlast  (tx_tlast),
        .tx_tid    (tx_tid)
    );

endmodule

// ==== tb.f ====
+incdir+tests
hdl/stream_mux_pkg.sv
hdl/stream_mux_ingress.sv
hdl/stream_mux_node.sv
hdl/stream_mux_egress.sv
hdl/stream_mux_top.sv
tests/tb_stream_mux.sv

// ==== tests/tb_stream_mux_tasks.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reporting and compares
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

task automatic report_error(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    error_count++;
endtask

// a wait ran out, so later waits give up at once.
task automatic note_timeout(input string what);
    $display("Timed out waiting for %s.", what);
    error_count++;
    timed_out = 1'b1;
endtask

task automatic check_data(input tdata_t got, input tdata_t exp);
    if (got !== exp)
        report_error($sformatf("tdata %h, expected %h", got, exp));
endtask

task automatic check_keep(input tkeep_t got, input tkeep_t exp);
    if (got !== exp)
        report_error($sformatf("tkeep %b, expected %b", got, exp));
endtask

task automatic check_id(input tid_t got, input tid_t exp);
    if (got !== exp)
        report_error($sformatf("tid %0d, expected %0d", got, exp));
endtask

task automatic check_last(input bit got, input bit exp);
    if (got !== exp)
        report_error($sformatf("tlast %0b, expected %0b", got, exp));
endtask

task automatic check_count(input int got, input int exp, input string what);
    if (got != exp)
        report_error($sformatf("%s %0d, expected %0d", what, got, exp));
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stimulus and monitor
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// closing beat keeps only the low bytes.
function automatic tkeep_t last_keep(input logic [31:0] seed);
    tkeep_t keep;
    keep = '1;
    return keep >> (seed % tdata_bytes);
endfunction

function automatic bit queues_empty();
    for (int s = 0; s < stream_inputs; s++) begin
        if (exp_data[s].size() != 0)
            return 1'b0;
    end
    return 1'b1;
endfunction

// one packet on rx src from 1 ns after an edge.
task automatic send_packet(input int src, input int len, input logic [31:0] seed);
    int cycles;
    for (int b = 0; b < len && !timed_out; b++) begin
        rx_tvalid[src] = 1'b1;
        rx_tdata[src]  = tdata_t'(seed + b);             // consecutive words.
        rx_tkeep[src]  = (b == len - 1) ? last_keep(seed) : '1;
        rx_tlast[src]  = (b == len - 1);
        cycles = 0;
        @(negedge aclk);
        while (!rx_tready[src] && cycles < wait_limit) begin
            @(negedge aclk);
            cycles++;
        end
        if (rx_tready[src]) begin
            // beat moves on the coming edge.
            exp_data[src].push_back(tdata_t'(seed + b));
            exp_keep[src].push_back(rx_tkeep[src]);
            exp_last[src].push_back(b == len - 1);
            rx_cycle[src] = cycle_no;
            sent_count++;
        end else begin
            note_timeout($sformatf("rx_tready on input %0d", src));
        end
        @(posedge aclk);
        #1;
    end
    rx_tvalid[src] = 1'b0;
    rx_tlast[src]  = 1'b0;
endtask

// packets back to back with no idle cycle.
task automatic send_train(input int src, input int count, input int len);
    for (int p = 0; p < count; p++)
        send_packet(src, len, $urandom);
endtask

// samples one tx beat at each falling edge.
task automatic collect();
    int src;
    if (!(tx_tvalid && tx_tready))
        return;
    src = int'(tx_tid);
    recv_count++;
    tx_cycle = cycle_no;
    log_tid.push_back(tx_tid);
    log_last.push_back(tx_tlast);
    if (src >= stream_inputs || exp_data[src].size() == 0) begin
        report_error($sformatf("beat with tid %0d that nobody sent", src));
        return;
    end
    check_data(tx_tdata, exp_data[src].pop_front());
    check_keep(tx_tkeep, exp_keep[src].pop_front());
    check_last(tx_tlast, exp_last[src].pop_front());
endtask

task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (!queues_empty() && !timed_out && cycles < drain_limit) begin
        @(posedge aclk);
        #1;
        cycles++;
    end
    if (!queues_empty() && !timed_out)
        note_timeout("tx to deliver every expected beat");
    repeat (4) @(posedge aclk);         // tree back to idle.
    #1;
endtask

// ==== tests/tb_stream_mux.sv ====
module tb_stream_mux
    import stream_mux_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int wait_limit  = 200;   // cycles per handshake.
    localparam int drain_limit = 1000;  // cycles to empty the tree.

    logic   aclk;
    logic   arst_n;
    logic   rx_tvalid [stream_inputs];
    logic   rx_tready [stream_inputs];
    tdata_t rx_tdata  [stream_inputs];
    tkeep_t rx_tkeep  [stream_inputs];
    logic   rx_tlast  [stream_inputs];
    logic   tx_tvalid;
    logic   tx_tready;
    tdata_t tx_tdata;
    tkeep_t tx_tkeep;
    logic   tx_tlast;
    tid_t   tx_tid;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // scoreboard
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    tdata_t exp_data [stream_inputs][$];    // per source in send order.
    tkeep_t exp_keep [stream_inputs][$];
    bit     exp_last [stream_inputs][$];
    tid_t   log_tid [$];                    // tx beats of the current test.
    bit     log_last [$];
    int     cycle_no = 0;
    int     rx_cycle [stream_inputs];       // edge count at last rx beat.
    int     tx_cycle;
    int     sent_count = 0;
    int     recv_count = 0;
    int     error_count = 0;
    int     tests_passed = 0;
    int     tests_failed = 0;
    bit     timed_out = 1'b0;
    bit     stall_on;

    `include "tb_stream_mux_tasks.svh"

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;            // 4 ns period.
    end

    always @(posedge aclk) cycle_no <= cycle_no + 1;

    always @(negedge aclk) begin
        if (arst_n)
            collect();                      // inputs are quiet at this edge.
    end

    stream_mux_top i_dut (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .rx_tvalid (rx_tvalid),
        .rx_tready (rx_tready),
        .rx_tdata  (rx_tdata),
        .rx_tkeep  (rx_tkeep),
        .rx_tlast  (rx_tlast),
        .tx_tvalid (tx_tvalid),
        .tx_tready (tx_tready),
        .tx_tdata  (tx_tdata),
        .tx_tkeep  (tx_tkeep),
        .tx_tlast  (tx_tlast),
        .tx_tid    (tx_tid)
    );

    task automatic finish_test(input string name, input int errs);
        if (error_count == errs) begin
            $display("test %s: passed", name);
            tests_passed++;
        end else begin
            $display("test %s: failed with %0d errors", name, error_count - errs);
            tests_failed++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic test_single_path();
        int errs;
        errs = error_count;
        if (tx_tvalid !== 1'b0)
            report_error("tx_tvalid is not low right after reset");
        for (int s = 0; s < stream_inputs; s++) begin
            log_tid.delete();
            log_last.delete();
            send_packet(s, 3 + s, $urandom);
            wait_drain();
            check_count(log_tid.size(), 3 + s, "beats on tx");
            foreach (log_tid[i])
                check_id(log_tid[i], tid_t'(s));   // stamped with its input.
        end
        finish_test("single path", errs);
    endtask

    task automatic test_latency();
        int errs;
        errs = error_count;
        send_packet(2, 1, $urandom);        // lone beat on an idle tree.
        wait_drain();
        check_count(tx_cycle - rx_cycle[2], tree_depth + 1, "cycles from rx to tx");
        finish_test("latency", errs);
    endtask

    task automatic test_no_interleave();
        int errs;
        int sent0;
        int recv0;
        errs = error_count;
        sent0 = sent_count;
        recv0 = recv_count;
        log_tid.delete();
        log_last.delete();
        fork
            send_train(0, 2, 4);
            send_train(1, 2, 5);
            send_train(2, 2, 6);
            send_train(3, 2, 3);
        join
        wait_drain();
        for (int i = 1; i < log_tid.size(); i++) begin
            if (!log_last[i-1])
                check_id(log_tid[i], log_tid[i-1]);    // open packet keeps its owner.
        end
        if (log_last.size() > 0)
            check_last(log_last[$], 1'b1);
        check_count(recv_count - recv0, sent_count - sent0, "beats received");
        finish_test("no interleaving", errs);
    endtask

    task automatic test_fairness();
        int errs;
        tid_t pkt_tid [$];
        errs = error_count;
        log_tid.delete();
        log_last.delete();
        fork
            send_train(0, 4, 3);
            send_train(1, 4, 3);
        join
        wait_drain();
        foreach (log_last[i]) begin
            if (log_last[i])
                pkt_tid.push_back(log_tid[i]);  // owner of each packet.
        end
        check_count(pkt_tid.size(), 8, "packets on tx");
        for (int k = 1; k < pkt_tid.size(); k++)
            check_id(pkt_tid[k], (pkt_tid[k-1] == tid_t'(0)) ? tid_t'(1) : tid_t'(0));
        finish_test("fairness", errs);
    endtask

    task automatic test_backpressure();
        int errs;
        int sent0;
        int recv0;
        int cycles;
        errs = error_count;
        sent0 = sent_count;
        recv0 = recv_count;
        cycles = 0;
        stall_on = 1'b1;
        fork
            begin
                fork
                    send_train(0, 3, 4);
                    send_train(1, 3, 2);
                    send_train(2, 3, 5);
                    send_train(3, 3, 3);
                join
                stall_on = 1'b0;
            end
            while (stall_on && cycles < drain_limit) begin
                @(posedge aclk);
                #1;
                tx_tready = $urandom_range(1, 0);   // random stall pattern.
                cycles++;
            end
        join
        tx_tready = 1'b1;
        wait_drain();
        check_count(recv_count - recv0, sent_count - sent0, "beats received");
        finish_test("back-pressure", errs);
    endtask

    task automatic test_mid_stall();
        int errs;
        int sent0;
        int recv0;
        int cycles;
        bit saw_stall;
        errs = error_count;
        sent0 = sent_count;
        recv0 = recv_count;
        cycles = 0;
        saw_stall = 1'b0;
        fork
            send_packet(3, 12, $urandom);
            begin
                while (recv_count - recv0 < 4 && cycles < wait_limit) begin
                    @(posedge aclk);
                    #1;
                    cycles++;
                end
                if (recv_count - recv0 < 4)
                    note_timeout("the first beats of the stalled packet");
                tx_tready = 1'b0;
                repeat (20) begin               // stall while watching rx.
                    @(negedge aclk);
                    if (rx_tvalid[3] && !rx_tready[3])
                        saw_stall = 1'b1;       // beat offered and refused.
                    @(posedge aclk);
                    #1;
                end
                tx_tready = 1'b1;
            end
        join
        wait_drain();
        if (!saw_stall)
            report_error("rx_tready on input 3 stayed high through the whole stall");
        check_count(recv_count - recv0, sent_count - sent0, "beats received");
        finish_test("mid-packet stall", errs);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        void'($urandom(32'h9b667488));
        arst_n    = 1'b0;
        tx_tready = 1'b1;
        for (int s = 0; s < stream_inputs; s++) begin
            rx_tvalid[s] = 1'b0;
            rx_tdata[s]  = '0;
            rx_tkeep[s]  = '0;
            rx_tlast[s]  = 1'b0;
            rx_cycle[s]  = 0;
        end
        repeat (10) @(posedge aclk);
        #1;
        arst_n = 1'b1;
        test_single_path();
        if (!timed_out)
            test_latency();
        if (!timed_out)
            test_no_interleave();
        if (!timed_out)
            test_fairness();
        if (!timed_out)
            test_backpressure();
        if (!timed_out)
            test_mid_stall();
        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (error_count == 0 && !timed_out)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule
